/* Makefile */
# Verilator simulation of the AXI burst planner
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_axi_burst_planner
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= NO ERRORS

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/axi_burst_pkg.sv */
`default_nettype none

package axi_burst_pkg;

   // Data path geometry, fixed at 32 bits
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;           // Bytes per beat
   localparam int OFFSET_W = $clog2(STRB_W);     // Byte lane bits of an address

   // AXI burst limits
   localparam int AXLEN_W = 8;
   localparam int MAX_BURST_BYTES = (1 << AXLEN_W) * STRB_W;  // 256 beats of 4 bytes
   localparam int BOUNDARY_BYTES = 4096;         // No burst may cross this
   localparam int BOUNDARY_W = $clog2(BOUNDARY_BYTES);

   // Transfer length in bytes
   localparam int LEN_W = 16;

   // Command opcodes as seen on the top-level port
   typedef enum logic [1:0] {
      OP_NOP      = 2'd0,
      OP_TRANSFER = 2'd1,
      OP_ABORT    = 2'd2
   } cmd_op_t;

   // Command decoder states
   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,
      ST_START = 2'd1,  // Controller loads the new transfer
      ST_RUN   = 2'd2   // Bursts are being issued
   } plan_state_t;

endpackage

`default_nettype wire

/* filelist.f */
common/axi_burst_pkg.sv
src/transfer_cmd_decode.sv
transfer_ctrl/axi_transfer_ctrl.sv
src/burst_issue.sv
src/axi_burst_planner.sv
testbench/axi_burst_planner_assertions.sv
testbench/tb_axi_burst_planner.sv

/* src/axi_burst_planner.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_burst_planner (
   input  wire logic                              clk_i,
   input  wire logic                              rst_i,
   input  wire logic                              cmd_valid_i,
   input  wire axi_burst_pkg::cmd_op_t            cmd_op_i,
   input  wire logic [axi_burst_pkg::ADDR_W-1:0]  cmd_addr_i,
   input  wire logic [axi_burst_pkg::LEN_W-1:0]   cmd_len_i,
   input  wire logic                              burst_accept_i,
   output logic                                   busy_o,
   output logic                                   cmd_error_o,
   output logic                                   burst_valid_o,
   output logic      [axi_burst_pkg::ADDR_W-1:0]  burst_addr_o,
   output logic      [axi_burst_pkg::AXLEN_W-1:0] burst_len_o,
   output logic      [axi_burst_pkg::STRB_W-1:0]  burst_first_strb_o,
   output logic      [axi_burst_pkg::STRB_W-1:0]  burst_last_strb_o,
   output logic                                   done_o
);
   import axi_burst_pkg::*;

   // Decoder side
   logic              transfer_start;
   logic              abort;
   logic [ADDR_W-1:0] xfer_addr;
   logic [LEN_W-1:0]  xfer_len;

   // Controller side
   logic [ADDR_W-1:0]  axaddr;
   logic [AXLEN_W-1:0] axlen;
   logic [STRB_W-1:0]  initial_strb;
   logic [STRB_W-1:0]  final_strb;
   logic               first_burst;
   logic               last_burst;

   // Issue side
   logic burst_start;
   logic finished;

   transfer_cmd_decode transfer_cmd_decode_inst (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .cmd_valid_i (cmd_valid_i),
      .cmd_op_i    (cmd_op_i),
      .cmd_addr_i  (cmd_addr_i),
      .cmd_len_i   (cmd_len_i),
      .finished_i  (finished),
      .busy_o      (busy_o),
      .cmd_error_o (cmd_error_o),
      .start_o     (transfer_start),
      .abort_o     (abort),
      .addr_o      (xfer_addr),
      .len_o       (xfer_len)
   );

   axi_transfer_ctrl axi_transfer_ctrl_inst (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .address_i        (xfer_addr),
      .length_i         (xfer_len),
      .transfer_start_i (transfer_start),
      .burst_start_i    (burst_start),
      .axaddr_o         (axaddr),
      .axlen_o          (axlen),
      .initial_strb_o   (initial_strb),
      .final_strb_o     (final_strb),
      .first_burst_o    (first_burst),
      .last_burst_o     (last_burst)
   );

   burst_issue burst_issue_inst (
      .clk_i              (clk_i),
      .rst_i              (rst_i),
      .start_i            (transfer_start),
      .abort_i            (abort),
      .burst_accept_i     (burst_accept_i),
      .axaddr_i           (axaddr),
      .axlen_i            (axlen),
      .initial_strb_i     (initial_strb),
      .final_strb_i       (final_strb),
      .first_burst_i      (first_burst),
      .last_burst_i       (last_burst),
      .burst_start_o      (burst_start),
      .finished_o         (finished),
      .burst_valid_o      (burst_valid_o),
      .burst_addr_o       (burst_addr_o),
      .burst_len_o        (burst_len_o),
      .burst_first_strb_o (burst_first_strb_o),
      .burst_last_strb_o  (burst_last_strb_o),
      .done_o             (done_o)
   );

endmodule

`default_nettype wire

/* src/burst_issue.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_issue (
   input  wire logic                              clk_i,
   input  wire logic                              rst_i,
   input  wire logic                              start_i,
   input  wire logic                              abort_i,
   input  wire logic                              burst_accept_i,
   input  wire logic [axi_burst_pkg::ADDR_W-1:0]  axaddr_i,
   input  wire logic [axi_burst_pkg::AXLEN_W-1:0] axlen_i,
   input  wire logic [axi_burst_pkg::STRB_W-1:0]  initial_strb_i,
   input  wire logic [axi_burst_pkg::STRB_W-1:0]  final_strb_i,
   input  wire logic                              first_burst_i,
   input  wire logic                              last_burst_i,
   output logic                                   burst_start_o,
   output logic                                   finished_o,
   output logic                                   burst_valid_o,
   output logic      [axi_burst_pkg::ADDR_W-1:0]  burst_addr_o,
   output logic      [axi_burst_pkg::AXLEN_W-1:0] burst_len_o,
   output logic      [axi_burst_pkg::STRB_W-1:0]  burst_first_strb_o,
   output logic      [axi_burst_pkg::STRB_W-1:0]  burst_last_strb_o,
   output logic                                   done_o
);
   import axi_burst_pkg::*;

   logic load_pending;  // Controller loads on start, its fields settle one cycle later
   logic accepted;
   logic single_beat;

   assign accepted      = burst_valid_o && burst_accept_i;
   assign burst_start_o = accepted;
   assign finished_o    = accepted && last_burst_i;

   // The controller holds its state until burst_start, so the
   // fields below stay steady while a burst waits for acceptance
   assign burst_addr_o = axaddr_i;
   assign burst_len_o  = axlen_i;

   assign single_beat = first_burst_i && last_burst_i && (axlen_i == '0);

   always_comb begin
      burst_first_strb_o = first_burst_i ? initial_strb_i : {STRB_W{1'b1}};
      burst_last_strb_o  = last_burst_i ? final_strb_i : {STRB_W{1'b1}};

      // One beat carries both the leading and the trailing lane limits
      if (single_beat) begin
         burst_first_strb_o = initial_strb_i & final_strb_i;
         burst_last_strb_o  = initial_strb_i & final_strb_i;
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         load_pending  <= 1'b0;
         burst_valid_o <= 1'b0;
         done_o        <= 1'b0;
      end else begin
         load_pending <= start_i && !abort_i;
         done_o       <= finished_o && !abort_i;  // An aborted transfer never reports done

         if (abort_i)
            burst_valid_o <= 1'b0;
         else if (load_pending)
            burst_valid_o <= 1'b1;
         else if (finished_o)
            burst_valid_o <= 1'b0;  // Between bursts valid just stays high
      end
   end

endmodule

`default_nettype wire

/* src/transfer_cmd_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module transfer_cmd_decode (
   input  wire logic                           clk_i,
   input  wire logic                           rst_i,
   input  wire logic                           cmd_valid_i,
   input  wire axi_burst_pkg::cmd_op_t         cmd_op_i,
   input  wire logic [axi_burst_pkg::ADDR_W-1:0] cmd_addr_i,
   input  wire logic [axi_burst_pkg::LEN_W-1:0]  cmd_len_i,
   input  wire logic                           finished_i,  // Last burst accepted
   output logic                                busy_o,
   output logic                                cmd_error_o,
   output logic                                start_o,
   output logic                                abort_o,
   output logic [axi_burst_pkg::ADDR_W-1:0]    addr_o,
   output logic [axi_burst_pkg::LEN_W-1:0]     len_o
);
   import axi_burst_pkg::*;

   plan_state_t state;
   logic        is_transfer;
   logic        is_abort;
   logic        len_zero;

   assign is_transfer = cmd_valid_i && (cmd_op_i == OP_TRANSFER);
   assign is_abort    = cmd_valid_i && (cmd_op_i == OP_ABORT);
   assign len_zero    = (cmd_len_i == '0);

   assign busy_o  = (state != ST_IDLE);
   assign start_o = (state == ST_START);  // One cycle, right after the accepting edge

   // Abort acts at the next edge, so it cannot wait for a register
   assign abort_o = is_abort && busy_o;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state       <= ST_IDLE;
         cmd_error_o <= 1'b0;
      end else begin
         cmd_error_o <= is_transfer && (busy_o || len_zero);

         case (state)
            ST_IDLE: begin
               if (is_transfer && !len_zero)
                  state <= ST_START;
            end
            ST_START: begin
               state <= abort_o ? ST_IDLE : ST_RUN;
            end
            ST_RUN: begin
               if (abort_o || finished_i)
                  state <= ST_IDLE;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Command fields stay put for the whole transfer
   always_ff @(posedge clk_i) begin
      if ((state == ST_IDLE) && is_transfer && !len_zero) begin
         addr_o <= cmd_addr_i;
         len_o  <= cmd_len_i;
      end
   end

endmodule

`default_nettype wire

/* testbench/axi_burst_planner_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_burst_planner_assertions (
   input wire logic                              clk_i,
   input wire logic                              rst_i,
   input wire logic                              busy_i,
   input wire logic                              cmd_error_i,
   input wire logic                              burst_valid_i,
   input wire logic                              burst_accept_i,
   input wire logic [axi_burst_pkg::ADDR_W-1:0]  burst_addr_i,
   input wire logic [axi_burst_pkg::AXLEN_W-1:0] burst_len_i,
   input wire logic [axi_burst_pkg::STRB_W-1:0]  burst_first_strb_i,
   input wire logic [axi_burst_pkg::STRB_W-1:0]  burst_last_strb_i,
   input wire logic                              done_i
);

   // A waiting burst keeps its fields until it is taken
   fields_held: assert property (@(posedge clk_i) disable iff (rst_i)
      (burst_valid_i && !burst_accept_i) |=> ($stable(burst_addr_i) && $stable(burst_len_i)
         && $stable(burst_first_strb_i) && $stable(burst_last_strb_i)))
   else $error("Burst fields changed while the burst waited for accept");

   done_apart: assert property (@(posedge clk_i) disable iff (rst_i)
      !(done_i && burst_valid_i))
   else $error("done_o and burst_valid_o were high together");

   quiet_in_reset: assert property (@(posedge clk_i)
      (rst_i && $past(rst_i)) |-> (!busy_i && !burst_valid_i && !done_i && !cmd_error_i))
   else $error("An output was active during reset");

endmodule

bind axi_burst_planner axi_burst_planner_assertions axi_burst_planner_assertions_inst (
   .clk_i              (clk_i),
   .rst_i              (rst_i),
   .busy_i             (busy_o),
   .cmd_error_i        (cmd_error_o),
   .burst_valid_i      (burst_valid_o),
   .burst_accept_i     (burst_accept_i),
   .burst_addr_i       (burst_addr_o),
   .burst_len_i        (burst_len_o),
   .burst_first_strb_i (burst_first_strb_o),
   .burst_last_strb_i  (burst_last_strb_o),
   .done_i             (done_o)
);

`default_nettype wire

/* testbench/tb_axi_burst_planner.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_burst_planner;
   import axi_burst_pkg::*;

   localparam int NUM_ROWS       = 14;
   localparam int RESET_CYCLES   = 10;
   localparam int TIMEOUT_CYCLES = NUM_ROWS * 64 + RESET_CYCLES;
   localparam logic [7:0] NO_ABORT = 8'hFF;

   typedef struct packed {
      cmd_op_t             op;
      logic [ADDR_W-1:0]   addr;
      logic [LEN_W-1:0]    len;
      logic [7:0]          abort_after;  // Bursts accepted before the abort goes out
      logic                exp_err;      // Zero length, or a second command while busy
   } row_t;

   logic                clk_i;
   logic                rst_i;
   logic                cmd_valid_i;
   cmd_op_t             cmd_op_i;
   logic [ADDR_W-1:0]   cmd_addr_i;
   logic [LEN_W-1:0]    cmd_len_i;
   logic                burst_accept_i;
   logic                busy_o;
   logic                cmd_error_o;
   logic                burst_valid_o;
   logic [ADDR_W-1:0]   burst_addr_o;
   logic [AXLEN_W-1:0]  burst_len_o;
   logic [STRB_W-1:0]   burst_first_strb_o;
   logic [STRB_W-1:0]   burst_last_strb_o;
   logic                done_o;

   row_t                rows [NUM_ROWS];
   int unsigned         cycles = 0;

   // Expected bursts of the current transfer
   logic [ADDR_W-1:0]   exp_addr_q [$];
   logic [AXLEN_W-1:0]  exp_len_q [$];
   logic [STRB_W-1:0]   exp_first_q [$];
   logic [STRB_W-1:0]   exp_last_q [$];

   axi_burst_planner axi_burst_planner_inst (
      .clk_i              (clk_i),
      .rst_i              (rst_i),
      .cmd_valid_i        (cmd_valid_i),
      .cmd_op_i           (cmd_op_i),
      .cmd_addr_i         (cmd_addr_i),
      .cmd_len_i          (cmd_len_i),
      .burst_accept_i     (burst_accept_i),
      .busy_o             (busy_o),
      .cmd_error_o        (cmd_error_o),
      .burst_valid_o      (burst_valid_o),
      .burst_addr_o       (burst_addr_o),
      .burst_len_o        (burst_len_o),
      .burst_first_strb_o (burst_first_strb_o),
      .burst_last_strb_o  (burst_last_strb_o),
      .done_o             (done_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES)
         report_failure("Timeout, the run did not finish within the cycle limit");
   end

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("ERRORS FOUND");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got == exp)
      else report_failure($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
   endtask

   task automatic load_table();
      rows[0]  = '{OP_TRANSFER, 32'h0000_1000, 16'd4,    NO_ABORT, 1'b0};
      rows[1]  = '{OP_TRANSFER, 32'h0000_2000, 16'd1024, NO_ABORT, 1'b0};
      rows[2]  = '{OP_TRANSFER, 32'h0000_0100, 16'd64,   NO_ABORT, 1'b0};
      rows[3]  = '{OP_TRANSFER, 32'h0001_0000, 16'd2500, NO_ABORT, 1'b0};  // 1024 limit
      rows[4]  = '{OP_TRANSFER, 32'h0000_0F00, 16'd512,  NO_ABORT, 1'b0};  // 4 KB split
      rows[5]  = '{OP_TRANSFER, 32'h0000_0E03, 16'd700,  NO_ABORT, 1'b0};
      rows[6]  = '{OP_TRANSFER, 32'h0000_3001, 16'd2,    NO_ABORT, 1'b0};  // Single beat
      rows[7]  = '{OP_TRANSFER, 32'h0000_4002, 16'd9,    NO_ABORT, 1'b0};
      rows[8]  = '{OP_TRANSFER, 32'h0000_5000, 16'd0,    NO_ABORT, 1'b1};
      rows[9]  = '{OP_TRANSFER, 32'h0000_6000, 16'd256,  NO_ABORT, 1'b1};
      rows[10] = '{OP_TRANSFER, 32'h0002_0000, 16'd4096, 8'd2,     1'b0};
      rows[11] = '{OP_TRANSFER, 32'h0002_0000, 16'd40,   NO_ABORT, 1'b0};
      rows[12] = '{OP_ABORT,    32'h0000_0000, 16'd0,    NO_ABORT, 1'b0};  // Idle abort
      rows[13] = '{OP_TRANSFER, 32'h0000_0FFE, 16'd3000, NO_ABORT, 1'b0};
   endtask

   // Splits a transfer by the burst rules into the expected queues
   task automatic build_expected(input logic [ADDR_W-1:0] addr, input logic [LEN_W-1:0] len);
      int unsigned       cur;
      int unsigned       left;
      int unsigned       lead;
      int unsigned       tail;
      int unsigned       data;
      int unsigned       beats_m1;
      logic              first;
      logic [STRB_W-1:0] init_strb;
      logic [STRB_W-1:0] fin_strb;
      logic [STRB_W-1:0] fs;
      logic [STRB_W-1:0] ls;
      exp_addr_q.delete();
      exp_len_q.delete();
      exp_first_q.delete();
      exp_last_q.delete();
      cur   = addr;
      left  = len;
      lead  = addr % STRB_W;
      tail  = (addr + len) % STRB_W;
      first = 1'b1;
      for (int i = 0; i < STRB_W; i++) begin
         init_strb[i] = (i >= lead) && (i < lead + len);
         fin_strb[i]  = (tail == 0) || (i < tail);
      end
      while (left > 0) begin
         data = left;
         if (BOUNDARY_BYTES - (cur % BOUNDARY_BYTES) < data)
            data = BOUNDARY_BYTES - (cur % BOUNDARY_BYTES);
         if (MAX_BURST_BYTES - lead < data)
            data = MAX_BURST_BYTES - lead;  // Offset bytes eat into the first burst
         beats_m1 = (data + lead + STRB_W - 1) / STRB_W - 1;
         fs = first ? init_strb : {STRB_W{1'b1}};
         ls = (data == left) ? fin_strb : {STRB_W{1'b1}};
         if (first && (data == left) && (beats_m1 == 0)) begin
            fs = init_strb & fin_strb;
            ls = init_strb & fin_strb;
         end
         exp_addr_q.push_back(cur & ~(STRB_W - 1));
         exp_len_q.push_back(beats_m1[AXLEN_W-1:0]);
         exp_first_q.push_back(fs);
         exp_last_q.push_back(ls);
         cur   = cur + data;
         left  = left - data;
         lead  = 0;
         first = 1'b0;
      end
   endtask

   // Called on a falling edge, returns on the next one
   task automatic issue_command(input cmd_op_t op, input logic [ADDR_W-1:0] addr,
                                input logic [LEN_W-1:0] len);
      cmd_valid_i = 1'b1;
      cmd_op_i    = op;
      cmd_addr_i  = addr;
      cmd_len_i   = len;
      @(negedge clk_i);
      cmd_valid_i = 1'b0;
      cmd_op_i    = OP_NOP;
   endtask

   task automatic wait_for_valid();
      int waited;
      waited = 0;
      while (!burst_valid_o && waited < 8) begin
         @(negedge clk_i);
         waited++;
      end
      assert (burst_valid_o)
      else report_failure("burst_valid_o never rose after an accepted command");
      check_value("burst_valid_o rise delay", waited, 2);
   endtask

   task automatic check_burst(input int k);
      check_value("burst_valid_o", burst_valid_o, 1);
      check_value("burst_addr_o", burst_addr_o, exp_addr_q[k]);
      check_value("burst_len_o", burst_len_o, exp_len_q[k]);
      check_value("burst_first_strb_o", burst_first_strb_o, exp_first_q[k]);
      check_value("burst_last_strb_o", burst_last_strb_o, exp_last_q[k]);
   endtask

   task automatic run_row(input row_t row);
      int delay;
      if (row.op != OP_TRANSFER) begin
         issue_command(row.op, row.addr, row.len);
         check_value("busy_o", busy_o, 0);
         check_value("cmd_error_o", cmd_error_o, 0);
         check_value("burst_valid_o", burst_valid_o, 0);
      end else if (row.len == '0) begin
         issue_command(row.op, row.addr, row.len);
         check_value("cmd_error_o", cmd_error_o, 1);
         check_value("busy_o", busy_o, 0);
         check_value("burst_valid_o", burst_valid_o, 0);
         @(negedge clk_i);
         check_value("cmd_error_o", cmd_error_o, 0);  // One cycle only
      end else begin
         build_expected(row.addr, row.len);
         issue_command(row.op, row.addr, row.len);
         check_value("busy_o", busy_o, 1);
         check_value("cmd_error_o", cmd_error_o, 0);
         wait_for_valid();
         if (row.exp_err) begin
            // Second transfer while busy must bounce off
            issue_command(OP_TRANSFER, row.addr + 32'h100, row.len);
            check_value("cmd_error_o", cmd_error_o, 1);
            check_value("busy_o", busy_o, 1);
         end
         for (int k = 0; k < exp_addr_q.size(); k++) begin
            check_burst(k);
            if (k == row.abort_after) begin
               issue_command(OP_ABORT, '0, '0);
               check_value("busy_o", busy_o, 0);
               check_value("burst_valid_o", burst_valid_o, 0);
               repeat (3) begin
                  check_value("done_o", done_o, 0);
                  @(negedge clk_i);
               end
               return;
            end
            delay = $urandom % 4;
            repeat (delay) begin
               @(negedge clk_i);
               check_burst(k);  // Held under back-pressure
            end
            burst_accept_i = 1'b1;
            @(negedge clk_i);
            burst_accept_i = 1'b0;
            if (k == exp_addr_q.size() - 1) begin
               check_value("done_o", done_o, 1);
               check_value("busy_o", busy_o, 0);
               check_value("burst_valid_o", burst_valid_o, 0);
               @(negedge clk_i);
               check_value("done_o", done_o, 0);
            end else begin
               check_value("done_o", done_o, 0);
               check_value("busy_o", busy_o, 1);
            end
         end
      end
   endtask

   initial begin
      void'($urandom(32'ha544));
      rst_i          = 1'b1;
      cmd_valid_i    = 1'b0;
      cmd_op_i       = OP_NOP;
      cmd_addr_i     = '0;
      cmd_len_i      = '0;
      burst_accept_i = 1'b0;
      load_table();
      repeat (RESET_CYCLES) @(negedge clk_i);
      rst_i = 1'b0;
      @(negedge clk_i);
      check_value("busy_o", busy_o, 0);
      check_value("burst_valid_o", burst_valid_o, 0);
      check_value("done_o", done_o, 0);
      check_value("cmd_error_o", cmd_error_o, 0);
      for (int r = 0; r < NUM_ROWS; r++)
         run_row(rows[r]);
      $display("NO ERRORS");
      $finish;
   end

endmodule

`default_nettype wire

/* transfer_ctrl/axi_transfer_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

// Walks a transfer burst by burst. Address and length inputs must hold
// for the whole transfer; the burst fields are combinational from the
// stored state and only move on transfer_start_i or burst_start_i
module axi_transfer_ctrl (
   input  wire logic                              clk_i,
   input  wire logic                              rst_i,
   input  wire logic [axi_burst_pkg::ADDR_W-1:0]  address_i,
   input  wire logic [axi_burst_pkg::LEN_W-1:0]   length_i,   // In bytes
   input  wire logic                              transfer_start_i,
   input  wire logic                              burst_start_i,
   output logic      [axi_burst_pkg::ADDR_W-1:0]  axaddr_o,   // Registered
   output logic      [axi_burst_pkg::AXLEN_W-1:0] axlen_o,
   output logic      [axi_burst_pkg::STRB_W-1:0]  initial_strb_o,
   output logic      [axi_burst_pkg::STRB_W-1:0]  final_strb_o,
   output logic                                   first_burst_o,
   output logic                                   last_burst_o
);
   import axi_burst_pkg::*;

   logic [LEN_W-1:0]    stored_len;     // Bytes not yet covered by a burst
   logic                first_q;
   logic [OFFSET_W-1:0] offset;

   logic [LEN_W:0]      span;           // Bytes from the aligned address to the end
   logic [LEN_W:0]      boundary_span;
   logic [LEN_W:0]      burst_span;
   logic [LEN_W:0]      beats_m1;

   logic [LEN_W:0]      end_byte;       // Transfer end, counted from the first beat
   logic [OFFSET_W-1:0] end_off;

   assign offset = address_i[OFFSET_W-1:0];

   // On the first burst the offset bytes ride along in front of the data.
   // Counting them into the span is the same as cutting the 1024-byte
   // limit and the boundary distance by the offset
   assign span = {1'b0, stored_len} + (first_q ? (LEN_W+1)'(offset) : '0);

   // Aligned address, so this is always a whole number of beats
   assign boundary_span = (LEN_W+1)'(BOUNDARY_BYTES)
                        - (LEN_W+1)'(axaddr_o[BOUNDARY_W-1:0]);

   always_comb begin
      burst_span = span;
      if (boundary_span < burst_span)
         burst_span = boundary_span;
      if ((LEN_W+1)'(MAX_BURST_BYTES) < burst_span)
         burst_span = (LEN_W+1)'(MAX_BURST_BYTES);
   end

   assign beats_m1 = (burst_span - 1'b1) >> OFFSET_W;  // Partial last beat rounds up
   assign axlen_o  = beats_m1[AXLEN_W-1:0];

   assign first_burst_o = first_q;
   assign last_burst_o  = (burst_span == span);

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         stored_len <= '0;
         first_q    <= 1'b0;
         axaddr_o   <= '0;
      end else if (transfer_start_i) begin
         stored_len <= length_i;
         first_q    <= 1'b1;
         axaddr_o   <= {address_i[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
      end else if (burst_start_i) begin
         // Whatever the burst did not cover is left for the next one
         stored_len <= LEN_W'(span - burst_span);
         first_q    <= 1'b0;
         axaddr_o   <= axaddr_o + ADDR_W'(burst_span);
      end
   end

   // Strobes depend only on the command, not on the burst being walked
   assign end_byte = {1'b0, length_i} + (LEN_W+1)'(offset);
   assign end_off  = end_byte[OFFSET_W-1:0];

   always_comb begin
      for (int i = 0; i < STRB_W; i++) begin
         // Lanes from the offset up, but no further than the transfer reaches
         initial_strb_o[i] = (i >= offset) && (i < end_byte);
         // A transfer ending on a beat edge fills its last beat
         final_strb_o[i]   = (end_off == '0) || (i < end_off);
      end
   end

endmodule

`default_nettype wire
